// ==== vec_mem_pkg.sv ====
`default_nettype none

package vec_mem_pkg;

    // ------------------------------------------------------------------------
    // bus and memory geometry
    // ------------------------------------------------------------------------
    localparam int ADDR_WIDTH     = 12;
    localparam int WORD_WIDTH     = 32;
    localparam int LANES          = 16;
    localparam int BUS_WIDTH      = LANES * WORD_WIDTH;
    localparam int ROW_WORDS      = 8;
    localparam int ROW_WIDTH      = ROW_WORDS * WORD_WIDTH;
    localparam int DMEM_ROW_BITS  = 8;
    localparam int IMEM_ADDR_BITS = 9;
    localparam int MAT_WIDTH      = 9 * WORD_WIDTH;

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    localparam logic [ADDR_WIDTH-1:0] DATA_BASE  = 12'h000;
    localparam logic [ADDR_WIDTH-1:0] TEXT_BASE  = 12'h800;
    localparam logic [ADDR_WIDTH-1:0] IO_ADDR    = 12'ha00;
    localparam logic [ADDR_WIDTH-1:0] MAT_L_ADDR = 12'ha03;
    localparam logic [ADDR_WIDTH-1:0] MAT_U_ADDR = 12'ha04;

    // other codes select a full 256-bit row
    typedef enum logic [2:0] {
        W32  = 3'd2,
        W64  = 3'd3,
        W128 = 3'd4
    } width_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic                  we;
        logic                  ren;
        width_e                width;
        logic [BUS_WIDTH-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [BUS_WIDTH-1:0] rdata;
    } mem_rsp_t;

    typedef logic [ROW_WIDTH-1:0]  row_t;
    typedef logic [WORD_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

// ==== sram_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_model #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 256
) (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            we,
    input  logic [$clog2(DEPTH)-1:0]        addr,
    input  logic [$bits(word_t)/32-1:0]     wmask,
    input  word_t                           wdata,
    output word_t                           rdata
);

    // one mask bit per 32-bit slice of the stored word
    localparam int SLICES = $bits(word_t) / 32;

    word_t mem [DEPTH];

    // ------------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int i = 0; i < SLICES; i++) begin
                if (wmask[i]) begin
                    mem[addr][i*32 +: 32] <= wdata[i*32 +: 32];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read port
    // ------------------------------------------------------------------------
    // data holds until the next read
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== mem_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_controller (
    input  logic                                  clk,
    input  logic                                  rst,
    input  vec_mem_pkg::mem_req_t                 req,
    input  logic [vec_mem_pkg::MAT_WIDTH-1:0]     mat_l,
    input  logic [vec_mem_pkg::MAT_WIDTH-1:0]     mat_u,
    input  vec_mem_pkg::row_t                     dmem_rdata,
    input  vec_mem_pkg::word_t                    imem_rdata,
    output vec_mem_pkg::mem_rsp_t                 rsp,
    output logic                                  dmem_en,
    output logic                                  dmem_we,
    output logic [vec_mem_pkg::DMEM_ROW_BITS-1:0] dmem_row,
    output logic [vec_mem_pkg::ROW_WORDS-1:0]     dmem_wmask,
    output vec_mem_pkg::row_t                     dmem_wdata,
    output logic                                  imem_en,
    output logic                                  imem_we,
    output logic [vec_mem_pkg::IMEM_ADDR_BITS-1:0] imem_addr,
    output vec_mem_pkg::word_t                    imem_wdata
);

    import vec_mem_pkg::*;

    localparam int OFF_BITS = $clog2(ROW_WORDS);

    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_DMEM,
        SRC_IMEM,
        SRC_MAT_L,
        SRC_MAT_U,
        SRC_IO
    } rd_src_e;

    logic                in_data;
    logic                in_text;
    logic                access;
    logic [OFF_BITS-1:0] word_off;
    logic [ROW_WORDS-1:0] size_mask;
    rd_src_e             rd_src_d;
    rd_src_e             rd_src_q;
    logic                valid_q;

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    assign in_data = req.addr[ADDR_WIDTH-1] == DATA_BASE[ADDR_WIDTH-1];
    assign in_text = req.addr[ADDR_WIDTH-1:IMEM_ADDR_BITS]
                     == TEXT_BASE[ADDR_WIDTH-1:IMEM_ADDR_BITS];
    assign access  = req.ren || req.we;

    always_comb begin
        if (in_data) begin
            rd_src_d = SRC_DMEM;
        end else if (in_text) begin
            rd_src_d = SRC_IMEM;
        end else if (req.addr == MAT_L_ADDR) begin
            rd_src_d = SRC_MAT_L;
        end else if (req.addr == MAT_U_ADDR) begin
            rd_src_d = SRC_MAT_U;
        end else if (req.addr == IO_ADDR) begin
            rd_src_d = SRC_IO;
        end else begin
            rd_src_d = SRC_NONE;
        end
    end

    // ------------------------------------------------------------------------
    // data memory port
    // ------------------------------------------------------------------------
    assign word_off = req.addr[OFF_BITS-1:0];
    assign dmem_row = req.addr[OFF_BITS +: DMEM_ROW_BITS];
    assign dmem_en  = in_data && access;
    assign dmem_we  = in_data && req.we;

    always_comb begin
        case (req.width)
            W32:     size_mask = ROW_WORDS'(1);
            W64:     size_mask = ROW_WORDS'(3);
            W128:    size_mask = ROW_WORDS'(15);
            default: size_mask = '1;
        endcase
    end

    // words shifted past the row end fall off
    assign dmem_wmask = size_mask << word_off;
    assign dmem_wdata = req.wdata[ROW_WIDTH-1:0] << (word_off * WORD_WIDTH);

    // ------------------------------------------------------------------------
    // instruction memory port
    // ------------------------------------------------------------------------
    assign imem_addr  = req.addr[IMEM_ADDR_BITS-1:0];
    assign imem_en    = in_text && access;
    assign imem_we    = in_text && req.we;
    assign imem_wdata = req.wdata[WORD_WIDTH-1:0];

    // ------------------------------------------------------------------------
    // read response
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_src_q <= SRC_NONE;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= req.ren;
            if (req.ren) begin
                rd_src_q <= rd_src_d;
            end
        end
    end

    always_comb begin
        rsp.valid = valid_q;
        rsp.rdata = '0;
        case (rd_src_q)
            SRC_DMEM:  rsp.rdata[ROW_WIDTH-1:0]  = dmem_rdata;
            SRC_IMEM:  rsp.rdata[WORD_WIDTH-1:0] = imem_rdata;
            SRC_MAT_L: rsp.rdata[MAT_WIDTH-1:0]  = mat_l;
            SRC_MAT_U: rsp.rdata[MAT_WIDTH-1:0]  = mat_u;
            // io and unmapped reads return zero
            default:   rsp.rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== vec_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module vec_mem_top #(
    parameter int DMEM_ROWS  = 256,
    parameter int IMEM_WORDS = 512
) (
    input  logic                              clk,
    input  logic                              rst,
    input  vec_mem_pkg::mem_req_t             req,
    input  logic [vec_mem_pkg::MAT_WIDTH-1:0] mat_l,
    input  logic [vec_mem_pkg::MAT_WIDTH-1:0] mat_u,
    output vec_mem_pkg::mem_rsp_t             rsp
);

    import vec_mem_pkg::*;

    // ------------------------------------------------------------------------
    // controller to memory wiring
    // ------------------------------------------------------------------------
    logic                      dmem_en;
    logic                      dmem_we;
    logic [DMEM_ROW_BITS-1:0]  dmem_row;
    logic [ROW_WORDS-1:0]      dmem_wmask;
    row_t                      dmem_wdata;
    row_t                      dmem_rdata;

    logic                      imem_en;
    logic                      imem_we;
    logic [IMEM_ADDR_BITS-1:0] imem_addr;
    word_t                     imem_wdata;
    word_t                     imem_rdata;

    mem_controller i_mem_controller (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .mat_l      (mat_l),
        .mat_u      (mat_u),
        .dmem_rdata (dmem_rdata),
        .imem_rdata (imem_rdata),
        .rsp        (rsp),
        .dmem_en    (dmem_en),
        .dmem_we    (dmem_we),
        .dmem_row   (dmem_row),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .imem_en    (imem_en),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata)
    );

    // 256-bit rows, one mask bit per lane
    sram_model #(
        .word_t (row_t),
        .DEPTH  (DMEM_ROWS)
    ) i_dmem (
        .clk   (clk),
        .en    (dmem_en),
        .we    (dmem_we),
        .addr  (dmem_row),
        .wmask (dmem_wmask),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    // instruction words are always written whole
    sram_model #(
        .word_t (word_t),
        .DEPTH  (IMEM_WORDS)
    ) i_imem (
        .clk   (clk),
        .en    (imem_en),
        .we    (imem_we),
        .addr  (imem_addr),
        .wmask (1'b1),
        .wdata (imem_wdata),
        .rdata (imem_rdata)
    );

endmodule

`default_nettype wire

// ==== vec_mem_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module vec_mem_assert (
    input  logic                  clk,
    input  logic                  rst,
    input  vec_mem_pkg::mem_req_t req,
    input  vec_mem_pkg::mem_rsp_t rsp,
    input  logic                  dmem_en,
    input  logic                  imem_en
);

    import vec_mem_pkg::*;

    // ------------------------------------------------------------------------
    // controller properties
    // ------------------------------------------------------------------------
    one_memory_enabled: assert property (
        @(posedge clk) disable iff (rst) !(dmem_en && imem_en)
    ) else $error("data and instruction memory enabled together");

    valid_after_read: assert property (
        @(posedge clk) disable iff (rst) req.ren |=> rsp.valid
    ) else $error("no response one cycle after a read strobe");

    no_valid_without_read: assert property (
        @(posedge clk) disable iff (rst) !req.ren |=> !rsp.valid
    ) else $error("response without a read strobe");

    // data region is the lower half of the map
    dmem_in_region: assert property (
        @(posedge clk) disable iff (rst) dmem_en |-> req.addr[ADDR_WIDTH-1] == 1'b0
    ) else $error("data memory enabled outside its region");

    imem_in_region: assert property (
        @(posedge clk) disable iff (rst) imem_en |-> req.addr[ADDR_WIDTH-1:9] == 3'b100
    ) else $error("instruction memory enabled outside its region");

endmodule

bind mem_controller vec_mem_assert i_vec_mem_assert (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .rsp     (rsp),
    .dmem_en (dmem_en),
    .imem_en (imem_en)
);

`default_nettype wire

// ==== vec_mem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vec_mem_tb;

    import vec_mem_pkg::*;

    localparam int DMEM_ROWS  = 256;
    localparam int IMEM_WORDS = 512;
    // reset plus all tests take about 110 cycles
    localparam int TEST_CYCLES    = 110;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'd97829;
    localparam width_e FULL_ROW = width_e'(3'd7);

    logic                 clk;
    logic                 rst;
    mem_req_t             req;
    logic [MAT_WIDTH-1:0] mat_l;
    logic [MAT_WIDTH-1:0] mat_u;
    mem_rsp_t             rsp;

    logic [31:0] lfsr_state;
    int          cycle_cnt = 0;
    int          error_count = 0;

    // reference copies of both memories
    row_t  shadow_dmem [DMEM_ROWS];
    word_t shadow_imem [IMEM_WORDS];

    vec_mem_top #(
        .DMEM_ROWS  (DMEM_ROWS),
        .IMEM_WORDS (IMEM_WORDS)
    ) i_vec_mem_top (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .mat_l (mat_l),
        .mat_u (mat_u),
        .rsp   (rsp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------------
    // random data and reference model
    // ------------------------------------------------------------------------
    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_word();
        logic        fb;
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            w = {w[30:0], fb};
        end
        return w;
    endfunction

    function automatic logic [BUS_WIDTH-1:0] rand_bus();
        logic [BUS_WIDTH-1:0] b;
        for (int i = 0; i < LANES; i++) begin
            b[i*32 +: 32] = rand_word();
        end
        return b;
    endfunction

    function automatic logic [MAT_WIDTH-1:0] rand_mat();
        logic [MAT_WIDTH-1:0] m;
        for (int i = 0; i < 9; i++) begin
            m[i*32 +: 32] = rand_word();
        end
        return m;
    endfunction

    function automatic void shadow_write(logic [ADDR_WIDTH-1:0] addr, width_e width,
                                         logic [BUS_WIDTH-1:0] wdata);
        int n;
        int off;
        int lane;
        case (width)
            W32:     n = 1;
            W64:     n = 2;
            W128:    n = 4;
            default: n = 8;
        endcase
        off = int'(addr[2:0]);
        if (addr[11] == 1'b0) begin
            // lanes shifted past word 7 are lost
            for (int i = 0; i < ROW_WORDS; i++) begin
                lane = i - off;
                if (lane >= 0 && lane < n) begin
                    shadow_dmem[addr[10:3]][i*32 +: 32] = wdata[lane*32 +: 32];
                end
            end
        end else if (addr[11:9] == 3'b100) begin
            shadow_imem[addr[8:0]] = wdata[31:0];
        end
    endfunction

    function automatic logic [BUS_WIDTH-1:0] expected_read(logic [ADDR_WIDTH-1:0] addr);
        logic [BUS_WIDTH-1:0] d;
        d = '0;
        if (addr[11] == 1'b0) begin
            d[ROW_WIDTH-1:0] = shadow_dmem[addr[10:3]];
        end else if (addr[11:9] == 3'b100) begin
            d[WORD_WIDTH-1:0] = shadow_imem[addr[8:0]];
        end else if (addr == MAT_L_ADDR) begin
            d[MAT_WIDTH-1:0] = mat_l;
        end else if (addr == MAT_U_ADDR) begin
            d[MAT_WIDTH-1:0] = mat_u;
        end
        return d;
    endfunction

    // ------------------------------------------------------------------------
    // driver and check tasks
    // ------------------------------------------------------------------------
    task automatic check(string name, logic [BUS_WIDTH-1:0] got, logic [BUS_WIDTH-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_idle();
        check("rsp.valid", BUS_WIDTH'(rsp.valid), '0);
    endtask

    task automatic check_rsp(logic [BUS_WIDTH-1:0] exp);
        check("rsp.valid", BUS_WIDTH'(rsp.valid), BUS_WIDTH'(1));
        check("rsp.rdata", rsp.rdata, exp);
    endtask

    task automatic write_req(logic [ADDR_WIDTH-1:0] addr, width_e width,
                             logic [BUS_WIDTH-1:0] wdata);
        req.addr  = addr;
        req.we    = 1'b1;
        req.ren   = 1'b0;
        req.width = width;
        req.wdata = wdata;
        shadow_write(addr, width, wdata);
        next_cycle();
        req = '0;
        check_idle();
    endtask

    task automatic read_req(logic [ADDR_WIDTH-1:0] addr);
        req.addr  = addr;
        req.we    = 1'b0;
        req.ren   = 1'b1;
        req.width = W32;
        req.wdata = '0;
    endtask

    task automatic expect_rsp(logic [BUS_WIDTH-1:0] exp);
        next_cycle();
        req = '0;
        check_rsp(exp);
    endtask

    task automatic read_check(logic [ADDR_WIDTH-1:0] addr);
        read_req(addr);
        expect_rsp(expected_read(addr));
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_full_row();
        logic [BUS_WIDTH-1:0] data;
        logic [BUS_WIDTH-1:0] exp;
        check_idle();
        data = rand_bus();
        write_req(12'h018, FULL_ROW, data);
        exp = '0;
        exp[ROW_WIDTH-1:0] = data[ROW_WIDTH-1:0];
        read_req(12'h018);
        check_idle();
        expect_rsp(exp);
        // response lasts a single cycle
        next_cycle();
        check_idle();
    endtask

    task automatic test_write_sizes();
        width_e                  sizes [4];
        logic [DMEM_ROW_BITS-1:0] row;
        logic [ADDR_WIDTH-1:0]   addr;
        sizes[0] = W32;
        sizes[1] = W64;
        sizes[2] = W128;
        sizes[3] = FULL_ROW;
        // row 0x24 catches words spilling out of row 0x23
        for (int s = 0; s < 5; s++) begin
            row = DMEM_ROW_BITS'(32 + s);
            write_req({1'b0, row, 3'b000}, width_e'(3'd0), rand_bus());
        end
        for (int s = 0; s < 4; s++) begin
            row = DMEM_ROW_BITS'(32 + s);
            for (int off = 0; off < ROW_WORDS; off++) begin
                addr = {1'b0, row, 3'(off)};
                write_req(addr, sizes[s], rand_bus());
                read_check(addr);
            end
        end
        for (int s = 0; s < 5; s++) begin
            row = DMEM_ROW_BITS'(32 + s);
            read_check({1'b0, row, 3'b000});
        end
    endtask

    task automatic test_text_region();
        logic [BUS_WIDTH-1:0] data;
        logic [BUS_WIDTH-1:0] exp;
        write_req(12'h100, FULL_ROW, rand_bus());
        data = rand_bus();
        write_req(12'h905, FULL_ROW, data);
        exp = '0;
        exp[WORD_WIDTH-1:0] = data[WORD_WIDTH-1:0];
        read_req(12'h905);
        expect_rsp(exp);
        read_check(12'h105);
        write_req(12'h9ff, W32, rand_bus());
        read_check(12'h9ff);
    endtask

    task automatic test_matrix_windows();
        logic [BUS_WIDTH-1:0] exp;
        mat_l = rand_mat();
        mat_u = rand_mat();
        exp = '0;
        exp[MAT_WIDTH-1:0] = mat_l;
        read_req(MAT_L_ADDR);
        expect_rsp(exp);
        exp[MAT_WIDTH-1:0] = mat_u;
        read_req(MAT_U_ADDR);
        expect_rsp(exp);
        // memory words that share the low address bits of the windows
        write_req(12'h200, FULL_ROW, rand_bus());
        write_req(12'h803, W32, rand_bus());
        write_req(12'h804, W32, rand_bus());
        write_req(MAT_L_ADDR, FULL_ROW, rand_bus());
        write_req(MAT_U_ADDR, FULL_ROW, rand_bus());
        read_check(MAT_L_ADDR);
        read_check(MAT_U_ADDR);
        read_check(12'h203);
        read_check(12'h803);
        read_check(12'h804);
    endtask

    task automatic test_unmapped_and_back_to_back();
        logic [ADDR_WIDTH-1:0] addrs [6];
        logic [BUS_WIDTH-1:0]  exps [6];
        read_req(IO_ADDR);
        expect_rsp('0);
        read_req(12'ha01);
        expect_rsp('0);
        read_req(12'hc00);
        expect_rsp('0);
        read_req(12'hfff);
        expect_rsp('0);
        addrs[0] = 12'h018;
        addrs[1] = 12'h905;
        addrs[2] = MAT_L_ADDR;
        addrs[3] = 12'ha01;
        addrs[4] = 12'h203;
        addrs[5] = MAT_U_ADDR;
        for (int i = 0; i < 6; i++) begin
            exps[i] = expected_read(addrs[i]);
        end
        // one strobe per cycle, each answered on the next
        read_req(addrs[0]);
        for (int i = 1; i < 6; i++) begin
            next_cycle();
            check_rsp(exps[i-1]);
            read_req(addrs[i]);
        end
        expect_rsp(exps[5]);
        next_cycle();
        check_idle();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req        = '0;
        mat_l      = '0;
        mat_u      = '0;
        lfsr_state = LFSR_SEED;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_full_row();
        test_write_sizes();
        test_text_region();
        test_matrix_windows();
        test_unmapped_and_back_to_back();
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vec_mem.f ====
vec_mem_pkg.sv
sram_model.sv
mem_controller.sv
vec_mem_top.sv
vec_mem_assert.sv
vec_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the vec_mem testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module vec_mem_tb -f vec_mem.f -o vec_mem_sim > "$LOG" 2>&1 \
    && ./obj_dir/vec_mem_sim >> "$LOG" 2>&1 \
    || echo "build or simulation returned a non-zero status" >> "$LOG"

cat "$LOG"

# a run that never reached the pass line also fails
grep -qxF "Finished with errors" "$LOG" && exit 1
grep -qxF "Finished with no errors" "$LOG" || exit 1
exit 0
